// File: rtl/movie_record_pkg.sv
package movie_record_pkg;

    // ----------------------------------------------------------------------
    // movie record layout, msb first
    // ----------------------------------------------------------------------
    localparam int rec_w       = 46;
    localparam int id_w        = 6;   // hall 3, slot 3
    localparam int id_msb      = 45;
    localparam int id_lsb      = 40;
    localparam int name_msb    = 39;
    localparam int name_lsb    = 35;
    localparam int price_w     = 10;
    localparam int price_msb   = 34;
    localparam int price_lsb   = 25;
    localparam int session_msb = 24;
    localparam int session_lsb = 10;
    localparam int day_w       = 3;
    localparam int day_msb     = 22;  // session bits 12..10
    localparam int day_lsb     = 20;
    localparam int rest_w      = 5;
    localparam int rest_msb    = 9;   // tickets left
    localparam int rest_lsb    = 5;
    localparam int seat_msb    = 4;
    localparam int seat_lsb    = 1;
    localparam int valid_bit   = 0;

    localparam int movie_depth = 8;
    localparam int idx_w       = 3;
    localparam int cnt_w       = 4;   // 0..8 movies
    localparam int off_w       = 5;   // vip discount factor
    localparam int off_scale   = 32;

endpackage

// File: rtl/box_office_pkg.sv
package box_office_pkg;

    localparam int btn_w = 3;
    localparam int op_w  = 2;
    localparam int st_w  = 3;

    // ----------------------------------------------------------------------
    // button codes
    // ----------------------------------------------------------------------
    localparam logic [btn_w-1:0] btn_next    = 3'b000;
    localparam logic [btn_w-1:0] btn_release = 3'b001;
    localparam logic [btn_w-1:0] btn_confirm = 3'b010;
    localparam logic [btn_w-1:0] btn_back    = 3'b011;
    localparam logic [btn_w-1:0] btn_cancel  = 3'b100;
    localparam logic [btn_w-1:0] btn_none    = 3'b111; // no press this cycle

    // store port operations
    localparam logic [op_w-1:0] op_idle       = 2'd0;
    localparam logic [op_w-1:0] op_read_index = 2'd1;
    localparam logic [op_w-1:0] op_write_id   = 2'd2;

    // ----------------------------------------------------------------------
    // booking states
    // ----------------------------------------------------------------------
    localparam logic [st_w-1:0] st_browse    = 3'd0;
    localparam logic [st_w-1:0] st_sold_out  = 3'd1;
    localparam logic [st_w-1:0] st_review    = 3'd2;
    localparam logic [st_w-1:0] st_vip_ask   = 3'd3;
    localparam logic [st_w-1:0] st_pin       = 3'd4;
    localparam logic [st_w-1:0] st_pin_error = 3'd5;
    localparam logic [st_w-1:0] st_issue     = 3'd6;
    localparam logic [st_w-1:0] st_receipt   = 3'd7;

endpackage

// File: rtl/movie_store.sv
`timescale 1ns/1ns

module movie_store (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   load_i,
    input  logic [movie_record_pkg::rec_w-1:0]     load_data_i,
    input  logic [box_office_pkg::op_w-1:0]        op_i,
    input  logic [movie_record_pkg::idx_w-1:0]     index_i,
    input  logic [movie_record_pkg::id_w-1:0]      id_i,
    input  logic [movie_record_pkg::rec_w-1:0]     wdata_i,
    output logic                                   done_o,
    output logic [movie_record_pkg::rec_w-1:0]     rdata_o,
    output logic [movie_record_pkg::cnt_w-1:0]     count_o
);
    import movie_record_pkg::*;
    import box_office_pkg::*;

    logic [rec_w-1:0]       table_q [movie_depth];
    logic [movie_depth-1:0] id_hit;
    logic                   accept;
    logic                   load_ok;

    assign accept  = (op_i != op_idle) && !done_o; // one request per two cycles
    assign load_ok = load_i && (count_o < movie_depth);

    always_comb begin
        for (int i = 0; i < movie_depth; i++) begin
            id_hit[i] = (i < count_o) && (table_q[i][id_msb:id_lsb] == id_i);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_o <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= accept;
            if (load_ok) count_o <= count_o + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok) begin
            table_q[count_o[idx_w-1:0]] <= load_data_i; // append
        end else if (accept && op_i == op_write_id) begin
            for (int i = 0; i < movie_depth; i++) begin
                if (id_hit[i]) table_q[i] <= wdata_i;
            end
        end
        if (accept && op_i == op_read_index) rdata_o <= table_q[index_i];
    end

    a_write_known_id: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && op_i == op_write_id) |-> (|id_hit))
        else $error("write to unknown movie id %h", id_i);

endmodule

// File: rtl/movie_port_arbiter.sv
`timescale 1ns/1ns

module movie_port_arbiter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [box_office_pkg::op_w-1:0]     br_op_i,
    input  logic [movie_record_pkg::idx_w-1:0]  br_index_i,
    output logic                                br_done_o,
    input  logic [box_office_pkg::op_w-1:0]     is_op_i,
    input  logic [movie_record_pkg::id_w-1:0]   is_id_i,
    input  logic [movie_record_pkg::rec_w-1:0]  is_wdata_i,
    output logic                                is_done_o,
    output logic [box_office_pkg::op_w-1:0]     st_op_o,
    output logic [movie_record_pkg::idx_w-1:0]  st_index_o,
    output logic [movie_record_pkg::id_w-1:0]   st_id_o,
    output logic [movie_record_pkg::rec_w-1:0]  st_wdata_o,
    input  logic                                st_done_i
);
    import box_office_pkg::*;

    logic is_sel;
    logic gnt_is_q; // owner of the request in flight

    assign is_sel     = (is_op_i != op_idle); // issuer first
    assign st_op_o    = is_sel ? is_op_i : br_op_i;
    assign st_index_o = br_index_i;
    assign st_id_o    = is_id_i;
    assign st_wdata_o = is_wdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_is_q <= 1'b0;
        end else if (st_op_o != op_idle && !st_done_i) begin
            gnt_is_q <= is_sel;
        end
    end

    assign br_done_o = st_done_i && !gnt_is_q;
    assign is_done_o = st_done_i && gnt_is_q;

    a_done_to_requester: assert property (@(posedge clk) disable iff (!rst_n)
        !(br_done_o && br_op_i == op_idle) && !(is_done_o && is_op_i == op_idle))
        else $error("done returned to a peer without a request");

endmodule

// File: rtl/movie_browser.sv
`timescale 1ns/1ns

module movie_browser (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                fetch_i,
    input  logic [box_office_pkg::btn_w-1:0]    press_i,
    input  logic [movie_record_pkg::cnt_w-1:0]  count_i,
    input  logic [movie_record_pkg::rec_w-1:0]  rdata_i,
    input  logic                                done_i,
    input  logic                                vip_member_i,
    input  logic [movie_record_pkg::day_w-1:0]  vip_day_i,
    output logic [box_office_pkg::op_w-1:0]     op_o,
    output logic [movie_record_pkg::idx_w-1:0]  index_o,
    output logic [movie_record_pkg::rec_w-1:0]  record_o,
    output logic                                record_valid_o,
    output logic                                vip_ok_o
);
    import movie_record_pkg::*;
    import box_office_pkg::*;

    logic [cnt_w-1:0] seen_cnt_q;
    logic             pend_q;
    logic             redo_q;     // index moved while a read was in flight
    logic             step_next;
    logic             step_back;
    logic             refetch;
    logic             take;

    assign step_next = (press_i == btn_next) && (cnt_w'(index_o) + 1'b1 < count_i);
    assign step_back = (press_i == btn_back) && (index_o != '0);
    assign refetch   = (count_i != '0) &&
                       (step_next || step_back || fetch_i || count_i != seen_cnt_q);
    assign take      = done_i && !redo_q && !refetch;
    assign op_o      = pend_q ? op_read_index : op_idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_o        <= '0;
            seen_cnt_q     <= '0;
            pend_q         <= 1'b0;
            redo_q         <= 1'b0;
            record_valid_o <= 1'b0;
            vip_ok_o       <= 1'b0;
        end else begin
            seen_cnt_q <= count_i;
            if (step_next) index_o <= index_o + 1'b1;
            else if (step_back) index_o <= index_o - 1'b1;

            if (refetch) begin
                pend_q         <= 1'b1;
                redo_q         <= pend_q && !done_i;
                record_valid_o <= 1'b0;
                vip_ok_o       <= 1'b0;
            end else if (done_i) begin
                redo_q <= 1'b0;
                if (take) begin
                    pend_q         <= 1'b0;
                    record_valid_o <= 1'b1;
                    vip_ok_o       <= vip_member_i && (rdata_i[day_msb:day_lsb] == vip_day_i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) record_o <= rdata_i;
    end

endmodule

// File: rtl/ticket_issuer.sv
`timescale 1ns/1ns

module ticket_issuer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  issue_i,
    input  logic                                  use_vip_i,
    input  logic [movie_record_pkg::rec_w-1:0]    record_i,
    input  logic [movie_record_pkg::off_w-1:0]    vip_off_i,
    input  logic                                  done_i,
    output logic [box_office_pkg::op_w-1:0]       op_o,
    output logic [movie_record_pkg::id_w-1:0]     id_o,
    output logic [movie_record_pkg::rec_w-1:0]    wdata_o,
    output logic                                  issue_done_o,
    output logic [movie_record_pkg::price_w-1:0]  price_o,
    output logic [5:0]                            ticket_id_o
);
    import movie_record_pkg::*;
    import box_office_pkg::*;

    logic                       req_q;
    logic [price_w-1:0]         list_price;
    logic [price_w+off_w-1:0]   vip_product;
    logic [rest_w-1:0]          rest_left;

    assign list_price  = record_i[price_msb:price_lsb];
    assign vip_product = list_price * vip_off_i;
    assign rest_left   = record_i[rest_msb:rest_lsb] - 1'b1;

    assign op_o         = req_q ? op_write_id : op_idle;
    assign id_o         = wdata_o[id_msb:id_lsb];
    assign issue_done_o = done_i && req_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q       <= 1'b0;
            ticket_id_o <= 6'd1;
        end else begin
            if (issue_i) req_q <= 1'b1;
            else if (done_i) req_q <= 1'b0;

            if (issue_done_o) begin
                ticket_id_o <= (ticket_id_o == 6'd63) ? 6'd1 : ticket_id_o + 1'b1; // skip 0
            end
        end
    end

    // ----------------------------------------------------------------------
    // price and write-back record
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (issue_i) begin
            price_o <= use_vip_i ? price_w'(vip_product / off_scale) : list_price;
            wdata_o <= {record_i[rec_w-1:rest_msb+1], rest_left, record_i[rest_lsb-1:0]};
        end
    end

    a_rest_positive: assert property (@(posedge clk) disable iff (!rst_n)
        issue_i |-> (record_i[rest_msb:rest_lsb] != '0))
        else $error("ticket issued for sold out movie");

endmodule

// File: rtl/booking_fsm.sv
`timescale 1ns/1ns

module booking_fsm (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [box_office_pkg::btn_w-1:0]  press_i,
    input  logic [7:0]                        switch_i,
    input  logic                              pin_valid_i,
    input  logic [19:0]                       pin_i,
    input  logic [19:0]                       vip_pin_i,
    input  logic                              record_valid_i,
    input  logic [4:0]                        rest_i,
    input  logic                              vip_ok_i,
    input  logic                              issue_done_i,
    output logic [box_office_pkg::st_w-1:0]   state_o,
    output logic                              fetch_o,
    output logic                              issue_o,
    output logic                              use_vip_o
);
    import box_office_pkg::*;

    logic [st_w-1:0] state_d;
    logic            enter_issue;

    assign enter_issue = (state_d == st_issue) && (state_o != st_issue);

    // ----------------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_d = state_o;
        case (state_o)
            st_browse: begin
                if (press_i == btn_confirm && record_valid_i) begin
                    state_d = (rest_i == '0) ? st_sold_out : st_review;
                end
            end
            st_sold_out: begin
                if (press_i == btn_confirm || press_i == btn_release) state_d = st_browse;
            end
            st_review: begin
                if (press_i == btn_confirm) state_d = vip_ok_i ? st_vip_ask : st_issue;
                else if (press_i == btn_release || press_i == btn_cancel) state_d = st_browse;
            end
            st_vip_ask: begin
                if (press_i == btn_confirm) begin
                    if (switch_i == 8'h01) state_d = st_issue;    // pay list price
                    else if (switch_i == 8'h02) state_d = st_pin; // vip payment
                end
            end
            st_pin: begin
                if (pin_valid_i) state_d = (pin_i == vip_pin_i) ? st_issue : st_pin_error;
            end
            st_pin_error: begin
                if (press_i == btn_confirm) state_d = st_pin;
                else if (press_i == btn_release) state_d = st_vip_ask;
            end
            st_issue: begin
                if (issue_done_i) state_d = st_receipt;
            end
            st_receipt: begin
                if (press_i != btn_none) state_d = st_browse;
            end
            default: state_d = st_browse;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_o   <= st_browse;
            fetch_o   <= 1'b0;
            issue_o   <= 1'b0;
            use_vip_o <= 1'b0;
        end else begin
            state_o <= state_d;
            fetch_o <= (state_o == st_receipt) && (state_d == st_browse); // rest changed
            issue_o <= enter_issue;
            if (enter_issue) use_vip_o <= (state_o == st_pin);
        end
    end

endmodule

// File: rtl/box_office_top.sv
`timescale 1ns/1ns

module box_office_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  load_i,
    input  logic [movie_record_pkg::rec_w-1:0]    load_data_i,
    input  logic [2:0]                            press_i,
    input  logic [7:0]                            switch_i,
    input  logic                                  pin_valid_i,
    input  logic [19:0]                           pin_i,
    input  logic                                  vip_member_i,
    input  logic [movie_record_pkg::day_w-1:0]    vip_day_i,
    input  logic [19:0]                           vip_pin_i,
    input  logic [movie_record_pkg::off_w-1:0]    vip_off_i,
    output logic [2:0]                            state_o,
    output logic [movie_record_pkg::rec_w-1:0]    movie_data_o,
    output logic                                  vip_ok_o,
    output logic [movie_record_pkg::price_w-1:0]  price_o,
    output logic [5:0]                            ticket_id_o,
    output logic                                  ticket_valid_o
);
    import movie_record_pkg::*;

    // store port and its two peers
    logic [1:0]       st_op, br_op, is_op;
    logic [idx_w-1:0] st_index, br_index;
    logic [id_w-1:0]  st_id, is_id;
    logic [rec_w-1:0] st_wdata, st_rdata, is_wdata;
    logic             st_done, br_done, is_done;
    logic [cnt_w-1:0] count;
    logic             record_valid, fetch, issue, use_vip;

    movie_store u_store (
        .clk(clk), .rst_n(rst_n), .load_i(load_i), .load_data_i(load_data_i),
        .op_i(st_op), .index_i(st_index), .id_i(st_id), .wdata_i(st_wdata),
        .done_o(st_done), .rdata_o(st_rdata), .count_o(count)
    );

    movie_port_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .br_op_i(br_op), .br_index_i(br_index), .br_done_o(br_done),
        .is_op_i(is_op), .is_id_i(is_id), .is_wdata_i(is_wdata), .is_done_o(is_done),
        .st_op_o(st_op), .st_index_o(st_index), .st_id_o(st_id), .st_wdata_o(st_wdata),
        .st_done_i(st_done)
    );

    movie_browser u_browser (
        .clk(clk), .rst_n(rst_n), .fetch_i(fetch), .press_i(press_i), .count_i(count),
        .rdata_i(st_rdata), .done_i(br_done), .vip_member_i(vip_member_i),
        .vip_day_i(vip_day_i), .op_o(br_op), .index_o(br_index), .record_o(movie_data_o),
        .record_valid_o(record_valid), .vip_ok_o(vip_ok_o)
    );

    ticket_issuer u_issuer (
        .clk(clk), .rst_n(rst_n), .issue_i(issue), .use_vip_i(use_vip),
        .record_i(movie_data_o), .vip_off_i(vip_off_i), .done_i(is_done),
        .op_o(is_op), .id_o(is_id), .wdata_o(is_wdata), .issue_done_o(ticket_valid_o),
        .price_o(price_o), .ticket_id_o(ticket_id_o)
    );

    booking_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .press_i(press_i), .switch_i(switch_i),
        .pin_valid_i(pin_valid_i), .pin_i(pin_i), .vip_pin_i(vip_pin_i),
        .record_valid_i(record_valid), .rest_i(movie_data_o[rest_msb:rest_lsb]),
        .vip_ok_i(vip_ok_o), .issue_done_i(ticket_valid_o),
        .state_o(state_o), .fetch_o(fetch), .issue_o(issue), .use_vip_o(use_vip)
    );

endmodule

// File: bench/box_office_model.svh
`ifndef BOX_OFFICE_MODEL_SVH
`define BOX_OFFICE_MODEL_SVH

// ----------------------------------------------------------------------
// reference model of the movie table and the ticket counter
// ----------------------------------------------------------------------
logic [rec_w-1:0] model_table [movie_depth];
int               model_count  = 0;
int               model_index  = 0;
int               model_sold   = 0;
logic [5:0]       model_ticket = 6'd1; // first ticket number

function automatic logic [price_w-1:0] list_price_of(input logic [rec_w-1:0] rec);
    return rec[price_msb:price_lsb];
endfunction

// price times factor, divided by 32, truncated
function automatic logic [price_w-1:0] vip_price_of(input logic [rec_w-1:0] rec,
                                                   input logic [off_w-1:0] off);
    int product;
    product = int'(rec[price_msb:price_lsb]) * int'(off);
    return price_w'(product / off_scale);
endfunction

function automatic logic [rest_w-1:0] rest_of(input logic [rec_w-1:0] rec);
    return rec[rest_msb:rest_lsb];
endfunction

function automatic logic vip_ok_of(input logic [rec_w-1:0] rec, input logic member,
                                   input logic [day_w-1:0] day);
    return member && (rec[day_msb:day_lsb] == day);
endfunction

// index clamps at both ends of the table
function automatic void step_model_index(input logic [btn_w-1:0] btn);
    if (btn == btn_next && model_index < model_count - 1) model_index++;
    else if (btn == btn_back && model_index > 0) model_index--;
endfunction

function automatic void book_model_ticket();
    model_table[model_index][rest_msb:rest_lsb] = rest_of(model_table[model_index]) - 1'b1;
    model_sold++;
    model_ticket = (model_ticket == 6'd63) ? 6'd1 : model_ticket + 6'd1;
endfunction

`endif

// File: bench/box_office_tb.sv
`timescale 1ns/1ns

module box_office_tb;
    import movie_record_pkg::*;
    import box_office_pkg::*;

    localparam int num_actions        = 40;
    localparam int presses_per_action = 6;
    localparam int max_cycles = 40 * (num_actions * presses_per_action + 2 * movie_depth) + 200;

    logic               clk;
    logic               rst_n;
    logic               load_i;
    logic [rec_w-1:0]   load_data_i;
    logic [2:0]         press_i;
    logic [7:0]         switch_i;
    logic               pin_valid_i;
    logic [19:0]        pin_i;
    logic               vip_member_i;
    logic [day_w-1:0]   vip_day_i;
    logic [19:0]        vip_pin_i;
    logic [off_w-1:0]   vip_off_i;
    logic [2:0]         state_o;
    logic [rec_w-1:0]   movie_data_o;
    logic               vip_ok_o;
    logic [price_w-1:0] price_o;
    logic [5:0]         ticket_id_o;
    logic               ticket_valid_o;

    int seed   = 9915;
    int cycles = 0;
    int pulses = 0;

    `include "box_office_model.svh"

    box_office_top uut (
        .clk(clk), .rst_n(rst_n), .load_i(load_i), .load_data_i(load_data_i),
        .press_i(press_i), .switch_i(switch_i), .pin_valid_i(pin_valid_i), .pin_i(pin_i),
        .vip_member_i(vip_member_i), .vip_day_i(vip_day_i), .vip_pin_i(vip_pin_i),
        .vip_off_i(vip_off_i), .state_o(state_o), .movie_data_o(movie_data_o),
        .vip_ok_o(vip_ok_o), .price_o(price_o), .ticket_id_o(ticket_id_o),
        .ticket_valid_o(ticket_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) report_error("timeout, the DUT stopped responding");
    end

    always @(negedge clk) begin
        if (ticket_valid_o) pulses <= pulses + 1; // one per issued ticket
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    task automatic press_button(input logic [2:0] code);
        @(negedge clk);
        press_i = code;
        @(negedge clk);
        press_i = btn_none;
    endtask

    task automatic enter_pin(input logic [19:0] pin);
        @(negedge clk);
        pin_i       = pin;
        pin_valid_i = 1'b1;
        @(negedge clk);
        pin_valid_i = 1'b0;
    endtask

    task automatic check_state(input logic [2:0] expected);
        assert (state_o == expected)
            else report_error($sformatf("mismatch state_o: got %h expected %h",
                                        state_o, expected));
    endtask

    task automatic check_record();
        logic [rec_w-1:0] rec;
        rec = model_table[model_index];
        assert (movie_data_o == rec)
            else report_error($sformatf("mismatch movie_data_o: got %h expected %h",
                                        movie_data_o, rec));
        assert (vip_ok_o == vip_ok_of(rec, vip_member_i, vip_day_i))
            else report_error($sformatf("mismatch vip_ok_o: got %h expected %h",
                                        vip_ok_o, vip_ok_of(rec, vip_member_i, vip_day_i)));
    endtask

    // valid drops the cycle after the index moves
    task automatic wait_record();
        @(negedge clk);
        while (!uut.record_valid) @(negedge clk);
        check_record();
    endtask

    task automatic wait_ticket(input logic [price_w-1:0] exp_price);
        while (!ticket_valid_o) @(negedge clk);
        assert (price_o == exp_price)
            else report_error($sformatf("mismatch price_o: got %h expected %h",
                                        price_o, exp_price));
        assert (ticket_id_o == model_ticket)
            else report_error($sformatf("mismatch ticket_id_o: got %h expected %h",
                                        ticket_id_o, model_ticket));
        book_model_ticket();
    endtask

    task automatic load_movies();
        logic [rec_w-1:0] rec;
        int               n;
        n = 5 + ($random(seed) & 3);
        for (int i = 0; i < n; i++) begin
            rec = '0;
            rec[id_msb:id_lsb]           = {3'(i), 3'($random(seed))}; // hall keeps ids unique
            rec[name_msb:name_lsb]       = 5'($random(seed));
            rec[price_msb:price_lsb]     = 10'($random(seed));
            rec[session_msb:session_lsb] = 15'($random(seed));
            if (i % 3 == 0) rec[day_msb:day_lsb] = vip_day_i;
            if (($random(seed) & 3) == 0) rec[rest_msb:rest_lsb] = '0;
            else rec[rest_msb:rest_lsb] = 5'(($random(seed) & 3) + 1);
            rec[seat_msb:seat_lsb]       = 4'($random(seed));
            rec[valid_bit]               = 1'b1;
            model_table[i] = rec;
            @(negedge clk);
            load_i      = 1'b1;
            load_data_i = rec;
        end
        model_count = n;
        @(negedge clk);
        load_i = 1'b0;
    endtask

    task automatic try_purchase();
        logic [rec_w-1:0]   rec;
        logic               vip;
        logic [price_w-1:0] exp_price;
        int                 pick;
        rec  = model_table[model_index];
        vip  = 1'b0;
        pick = $random(seed) & 7;
        press_button(btn_confirm);
        if (rest_of(rec) == '0) begin
            check_state(st_sold_out);
            press_button(btn_release);
            check_state(st_browse);
            check_record();
        end else if (pick == 0) begin
            check_state(st_review);
            press_button(btn_cancel);
            check_state(st_browse);
        end else begin
            check_state(st_review);
            press_button(btn_confirm);
            if (vip_ok_of(rec, vip_member_i, vip_day_i)) begin
                check_state(st_vip_ask);
                switch_i = (pick < 3) ? 8'h01 : 8'h02;
                press_button(btn_confirm);
                if (pick >= 3) begin
                    check_state(st_pin);
                    if (pick >= 6) begin
                        enter_pin(vip_pin_i + 20'd1);
                        check_state(st_pin_error);
                        press_button(btn_confirm);
                        check_state(st_pin);
                        assert (!ticket_valid_o)
                            else report_error("a ticket was issued after a wrong PIN");
                    end
                    enter_pin(vip_pin_i);
                    vip = 1'b1;
                end
            end
            check_state(st_issue);
            exp_price = vip ? vip_price_of(rec, vip_off_i) : list_price_of(rec);
            wait_ticket(exp_price);
            press_button(btn_release); // leave the receipt and re-read the store
            check_state(st_browse);
            wait_record();
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n        = 1'b0;
        load_i       = 1'b0;
        load_data_i  = '0;
        press_i      = btn_none;
        switch_i     = 8'h00;
        pin_valid_i  = 1'b0;
        pin_i        = '0;
        vip_member_i = 1'b1;
        vip_day_i    = 3'($random(seed));
        vip_pin_i    = 20'($random(seed));
        vip_off_i    = 5'($random(seed));
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        load_movies();
        wait_record();

        for (int a = 0; a < num_actions; a++) begin
            case ($random(seed) & 3)
                0: begin
                    press_button(btn_next);
                    step_model_index(btn_next);
                    wait_record();
                end
                1: begin
                    press_button(btn_back);
                    step_model_index(btn_back);
                    wait_record();
                end
                default: try_purchase();
            endcase
        end

        // sweep the whole table against the model
        while (model_index > 0) begin
            press_button(btn_back);
            step_model_index(btn_back);
            wait_record();
        end
        for (int i = 1; i < model_count; i++) begin
            press_button(btn_next);
            step_model_index(btn_next);
            wait_record();
        end

        assert (pulses == model_sold)
            else report_error($sformatf("mismatch ticket_valid_o pulses: got %h expected %h",
                                        pulses, model_sold));
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+bench
rtl/movie_record_pkg.sv
rtl/box_office_pkg.sv
rtl/movie_store.sv
rtl/movie_port_arbiter.sv
rtl/movie_browser.sv
rtl/ticket_issuer.sv
rtl/booking_fsm.sv
rtl/box_office_top.sv
bench/box_office_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module box_office_tb -o box_office_sim

./obj_dir/box_office_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
